//--- filelist.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/alu_branch_unit.sv
verilog/multiply_unit.sv
verilog/result_slot.sv
verilog/execute_stage.sv
sim/exec_tb_clk.sv
sim/exec_properties.sv
sim/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_tb -f filelist.f -o exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- sim/exec_stim.txt
// cmd unit op tag rd port_a port_b pc imm pred exp_wdata exp_redirect exp_redirect_addr
// cmd 0 op, 1 flush, 2 end; unit 0 arith, 1 branch, 2 jump, 3 mul
0 0 0 1 01 00000007 00000003 00000000 00000000 0 0000000a 0 00000000
0 0 1 2 02 00000005 00000008 00000000 00000000 0 fffffffd 0 00000000
0 3 0 3 03 00001234 00005678 00000000 00000000 0 06260060 0 00000000
0 0 2 4 04 f0f0ff00 0ff0f0f0 00000000 00000000 0 00f0f000 0 00000000
0 0 3 5 05 f0f0ff00 0ff0f0f0 00000000 00000000 0 fff0fff0 0 00000000
0 3 1 6 06 80000000 00000002 00000000 00000000 0 ffffffff 0 00000000
0 0 4 7 07 12345678 ffff0000 00000000 00000000 0 edcb5678 0 00000000
0 0 5 8 08 fffffffe 00000001 00000000 00000000 0 00000001 0 00000000
0 3 2 9 09 ffffffff ffffffff 00000000 00000000 0 ffffffff 0 00000000
0 0 6 a 0a fffffffe 00000001 00000000 00000000 0 00000000 0 00000000
0 3 3 b 0b ffffffff ffffffff 00000000 00000000 0 fffffffe 0 00000000
0 0 7 c 0c 00000003 00000024 00000000 00000000 0 00000030 0 00000000
0 0 8 d 0d 80000000 0000001f 00000000 00000000 0 00000001 0 00000000
0 3 0 e 0e fffffffd 00000007 00000000 00000000 0 ffffffeb 0 00000000
0 0 9 f 0f 80000000 00000004 00000000 00000000 0 f8000000 0 00000000
0 0 a 0 10 00000011 deadbeef 00000000 00000000 0 deadbeef 0 00000000
0 3 1 1 11 7fffffff 7fffffff 00000000 00000000 0 3fffffff 0 00000000
0 1 0 2 00 00000005 00000005 00000100 00000020 1 00000000 0 00000120
0 1 1 3 00 00000005 00000005 00000100 00000020 1 00000000 1 00000104
0 1 2 4 00 ffffffff 00000001 00000200 fffffff0 0 00000000 1 000001f0
0 1 3 5 00 ffffffff 00000001 00000200 fffffff0 0 00000000 0 00000204
0 1 4 6 00 ffffffff 00000001 00000300 00000040 1 00000000 1 00000304
0 1 5 7 00 ffffffff 00000001 00000300 00000040 0 00000000 1 00000340
0 2 0 8 01 00000000 00000000 00001000 00000100 0 00001004 1 00001100
0 2 1 9 05 00002003 00000000 00001000 00000010 0 00001004 1 00002012
0 3 0 a 1a 00000002 00000003 00000000 00000000 0 00000006 0 00000000
0 0 0 b 1b 00000001 00000001 00000000 00000000 0 00000002 0 00000000
1 0 0 0 00 00000000 00000000 00000000 00000000 0 00000000 0 00000000
0 0 0 c 1c 00000100 00000023 00000000 00000000 0 00000123 0 00000000
0 3 0 d 1d 00000010 00000010 00000000 00000000 0 00000100 0 00000000
2 0 0 0 00 00000000 00000000 00000000 00000000 0 00000000 0 00000000

//--- sim/exec_tb.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_tb;

  localparam int REC_W     = 13;
  localparam int MAX_REC   = 48;
  localparam int CMD_FLUSH = 1;
  localparam int CMD_END   = 2;
  localparam int DRIVE_DLY = 1;

  logic                    CLK;
  logic                    nRST;
  logic                    flush;
  logic                    issue_valid;
  logic                    issue_ready;
  exec_pkg::issue_t        issue;
  logic                    arith_valid;
  logic                    arith_ready;
  exec_pkg::arith_result_t arith_out;
  logic                    mul_valid;
  logic                    mul_ready;
  exec_pkg::mul_result_t   mul_out;

  logic [31:0]             stim_mem [MAX_REC*REC_W];
  exec_pkg::arith_result_t arith_q [$];
  exec_pkg::mul_result_t   mul_q [$];
  // expectation for the op currently offered on issue
  exec_pkg::arith_result_t arith_exp;
  exec_pkg::mul_result_t   mul_exp;

  exec_tb_clk u_clk (.CLK(CLK));

  execute_stage uut (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue),
    .arith_valid (arith_valid),
    .arith_ready (arith_ready),
    .arith_out   (arith_out),
    .mul_valid   (mul_valid),
    .mul_ready   (mul_ready),
    .mul_out     (mul_out)
  );

  bind execute_stage exec_properties u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue),
    .arith_valid (arith_valid),
    .arith_ready (arith_ready),
    .arith_out   (arith_out),
    .mul_valid   (mul_valid),
    .mul_ready   (mul_ready),
    .mul_out     (mul_out)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // index of the end marker or -1 without one
  function automatic int count_records();
    int n;
    n = -1;
    for (int k = MAX_REC - 1; k >= 0; k--) begin
      if (stim_mem[k*REC_W] == CMD_END) begin
        n = k;
      end
    end
    return n;
  endfunction

  task automatic load_op(input int rec);
    int base;
    base = rec * REC_W;
    issue.unit       = exec_pkg::exec_unit_e'(stim_mem[base+1][1:0]);
    issue.opcode     = stim_mem[base+2][3:0];
    issue.tag        = stim_mem[base+3][`EXEC_TAG_W-1:0];
    issue.rd         = stim_mem[base+4][`EXEC_REG_W-1:0];
    issue.port_a     = stim_mem[base+5];
    issue.port_b     = stim_mem[base+6];
    issue.pc         = stim_mem[base+7];
    issue.imm        = stim_mem[base+8];
    issue.prediction = stim_mem[base+9][0];
    issue_valid      = 1'b1;
    arith_exp.tag           = issue.tag;
    arith_exp.rd            = issue.rd;
    // branches write no register
    arith_exp.wen           = (issue.unit != exec_pkg::UNIT_BRANCH);
    arith_exp.wdata         = stim_mem[base+10];
    arith_exp.redirect      = stim_mem[base+11][0];
    arith_exp.redirect_addr = stim_mem[base+12];
    mul_exp.tag   = issue.tag;
    mul_exp.rd    = issue.rd;
    mul_exp.wdata = stim_mem[base+10];
  endtask

  task automatic check_arith();
    exec_pkg::arith_result_t want;
    if (arith_q.size() == 0) begin
      abort_run("arith result arrived with no operation outstanding");
    end else begin
      want = arith_q.pop_front();
      compare_value("arith_out.tag", 32'(arith_out.tag), 32'(want.tag));
      compare_value("arith_out.rd", 32'(arith_out.rd), 32'(want.rd));
      compare_value("arith_out.wen", 32'(arith_out.wen), 32'(want.wen));
      if (want.wen)
        compare_value("arith_out.wdata", arith_out.wdata, want.wdata);
      compare_value("arith_out.redirect", 32'(arith_out.redirect), 32'(want.redirect));
      // branches carry their resolved address even when predicted
      if (want.redirect || !want.wen)
        compare_value("arith_out.redirect_addr", arith_out.redirect_addr,
                      want.redirect_addr);
    end
  endtask

  task automatic check_mul();
    exec_pkg::mul_result_t want;
    if (mul_q.size() == 0) begin
      abort_run("mul result arrived with no operation outstanding");
    end else begin
      want = mul_q.pop_front();
      compare_value("mul_out.tag", 32'(mul_out.tag), 32'(want.tag));
      compare_value("mul_out.rd", 32'(mul_out.rd), 32'(want.rd));
      compare_value("mul_out.wdata", mul_out.wdata, want.wdata);
    end
  endtask

  initial begin
    int   n_rec;
    int   idx;
    int   cycles;
    logic issue_fire;
    nRST        = 1'b0;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    arith_ready = 1'b1;
    mul_ready   = 1'b1;
    void'($urandom(32'hc6cc));
    $readmemh("sim/exec_stim.txt", stim_mem);
    n_rec = count_records();
    if (n_rec < 1) begin
      abort_run("stimulus file holds no operations or no end marker");
    end
    repeat (5) @(posedge CLK);
    #(DRIVE_DLY);
    nRST   = 1'b1;
    idx    = 0;
    cycles = 0;
    while (idx < n_rec || issue_valid || arith_q.size() > 0 || mul_q.size() > 0) begin
      // handshakes are settled half a cycle before the edge
      @(negedge CLK);
      issue_fire = issue_valid && issue_ready;
      if (arith_valid && arith_ready)
        check_arith();
      if (mul_valid && mul_ready)
        check_mul();
      @(posedge CLK);
      #(DRIVE_DLY);
      cycles++;
      if (cycles > 40 * n_rec) begin
        abort_run("timeout with results still outstanding");
      end
      // flush took effect at this edge
      if (flush) begin
        flush = 1'b0;
        arith_q.delete();
        mul_q.delete();
      end
      if (issue_fire) begin
        if (issue.unit == exec_pkg::UNIT_MUL)
          mul_q.push_back(mul_exp);
        else
          arith_q.push_back(arith_exp);
        issue_valid = 1'b0;
      end
      if (!issue_valid && idx < n_rec) begin
        if (stim_mem[idx*REC_W] == CMD_FLUSH)
          flush = 1'b1;
        else
          load_op(idx);
        idx++;
      end
      // roughly 70 percent ready on each channel
      arith_ready = ($urandom % 10) < 7;
      mul_ready   = ($urandom % 10) < 7;
    end
    // no stray result once every expectation is met
    repeat (8) begin
      @(negedge CLK);
      if (arith_valid || mul_valid) begin
        abort_run("result appeared after all expected results");
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sim/exec_properties.sv
`timescale 1ns/1ps

module exec_properties (
  input logic                    CLK,
  input logic                    nRST,
  input logic                    flush,
  input logic                    issue_valid,
  input logic                    issue_ready,
  input exec_pkg::issue_t        issue,
  input logic                    arith_valid,
  input logic                    arith_ready,
  input exec_pkg::arith_result_t arith_out,
  input logic                    mul_valid,
  input logic                    mul_ready,
  input exec_pkg::mul_result_t   mul_out
);

  logic arith_fire;
  logic mul_fire;

  assign arith_fire = issue_valid && issue_ready && (issue.unit != exec_pkg::UNIT_MUL);
  assign mul_fire   = issue_valid && issue_ready && (issue.unit == exec_pkg::UNIT_MUL);

  // stalled result holds until commit takes it
  arith_hold: assert property (@(posedge CLK) disable iff (!nRST)
    arith_valid && !arith_ready && !flush |=> arith_valid && $stable(arith_out))
    else $error("arith payload changed while stalled");

  mul_hold: assert property (@(posedge CLK) disable iff (!nRST)
    mul_valid && !mul_ready && !flush |=> mul_valid && $stable(mul_out))
    else $error("mul payload changed while stalled");

  flush_empties: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !arith_valid && !mul_valid)
    else $error("result still valid after flush");

  arith_latency: assert property (@(posedge CLK) disable iff (!nRST)
    arith_fire && !flush |=> arith_valid)
    else $error("arith result not valid one edge after issue");

  // three edges through the multiplier while commit keeps accepting
  mul_latency: assert property (@(posedge CLK) disable iff (!nRST)
    $past(mul_fire && !flush, 3) && $past(mul_ready && !flush, 2) &&
    $past(mul_ready && !flush, 1) |-> mul_valid)
    else $error("mul result not valid three edges after issue");

endmodule

//--- sim/exec_tb_clk.sv
`timescale 1ns/1ps

module exec_tb_clk (
  output logic CLK
);

  // 4 ns period
  localparam int HALF = 2;

  initial begin
    CLK = 1'b0;
    forever #(HALF) CLK = ~CLK;
  end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    flush,
  input  logic                    issue_valid,
  output logic                    issue_ready,
  input  exec_pkg::issue_t        issue,
  output logic                    arith_valid,
  input  logic                    arith_ready,
  output exec_pkg::arith_result_t arith_out,
  output logic                    mul_valid,
  input  logic                    mul_ready,
  output exec_pkg::mul_result_t   mul_out
);

  logic                    is_mul;
  logic                    arith_in_valid;
  logic                    arith_in_ready;
  exec_pkg::arith_result_t arith_result;
  logic                    mul_in_valid;
  logic                    mul_advance;
  logic                    mul_stage_valid;
  exec_pkg::mul_result_t   mul_stage_result;

  // steer by unit, arith/branch/jump share one channel
  assign is_mul         = (issue.unit == exec_pkg::UNIT_MUL);
  assign arith_in_valid = issue_valid && !is_mul;
  assign mul_in_valid   = issue_valid && is_mul;
  assign issue_ready    = is_mul ? mul_advance : arith_in_ready;

  alu_branch_unit u_alu (
    .op     (issue),
    .result (arith_result)
  );

  result_slot #(.payload_t(exec_pkg::arith_result_t)) u_arith_slot (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .in_valid  (arith_in_valid),
    .in_ready  (arith_in_ready),
    .in_data   (arith_result),
    .out_valid (arith_valid),
    .out_ready (arith_ready),
    .out_data  (arith_out)
  );

  // whole multiply pipe stalls while its slot cannot accept
  multiply_unit u_mul (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .in_valid  (mul_in_valid),
    .op        (issue),
    .advance   (mul_advance),
    .out_valid (mul_stage_valid),
    .result    (mul_stage_result)
  );

  result_slot #(.payload_t(exec_pkg::mul_result_t)) u_mul_slot (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .in_valid  (mul_stage_valid),
    .in_ready  (mul_advance),
    .in_data   (mul_stage_result),
    .out_valid (mul_valid),
    .out_ready (mul_ready),
    .out_data  (mul_out)
  );

endmodule

//--- verilog/result_slot.sv
`timescale 1ns/1ps

module result_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // accepts when empty or drained in the same cycle
  assign in_ready = !full || out_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (flush) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = data_q;

endmodule

//--- verilog/multiply_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module multiply_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  in_valid,
  input  exec_pkg::issue_t      op,
  input  logic                  advance,
  output logic                  out_valid,
  output exec_pkg::mul_result_t result
);

  localparam int XLEN = `EXEC_XLEN;
  localparam int NSTG = `EXEC_MUL_STAGES;

  // product stages ahead of the word select
  typedef struct packed {
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   high;
    logic [2*XLEN-1:0]      prod;
  } mul_stage_t;

  exec_pkg::mul_op_e     kind;
  logic                  a_signed;
  logic                  b_signed;
  logic signed [XLEN:0]  a_ext;
  logic signed [XLEN:0]  b_ext;
  logic signed [2*XLEN+1:0] full_prod;
  logic [NSTG-2:0]       stg_valid;
  mul_stage_t            stg [NSTG-1];
  logic                  out_valid_q;
  exec_pkg::mul_result_t out_q;

  assign kind = exec_pkg::mul_op_e'(op.opcode[1:0]);

  // rs1 is unsigned only for mulhu, rs2 signed for mul and mulh
  assign a_signed = (kind != exec_pkg::MUL_MULHU);
  assign b_signed = (kind == exec_pkg::MUL_MUL) || (kind == exec_pkg::MUL_MULH);

  assign a_ext     = {a_signed & op.port_a[XLEN-1], op.port_a};
  assign b_ext     = {b_signed & op.port_b[XLEN-1], op.port_b};
  assign full_prod = a_ext * b_ext;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      stg_valid   <= '0;
      out_valid_q <= 1'b0;
    end else if (flush) begin
      stg_valid   <= '0;
      out_valid_q <= 1'b0;
    end else if (advance) begin
      stg_valid[0] <= in_valid;
      for (int i = 1; i < NSTG - 1; i++) begin
        stg_valid[i] <= stg_valid[i-1];
      end
      out_valid_q <= stg_valid[NSTG-2];
    end
  end

  // tag and rd ride along with the product
  always_ff @(posedge CLK) begin
    if (advance) begin
      stg[0].tag  <= op.tag;
      stg[0].rd   <= op.rd;
      stg[0].high <= (kind != exec_pkg::MUL_MUL);
      stg[0].prod <= full_prod[2*XLEN-1:0];
      for (int i = 1; i < NSTG - 1; i++) begin
        stg[i] <= stg[i-1];
      end
      out_q.tag   <= stg[NSTG-2].tag;
      out_q.rd    <= stg[NSTG-2].rd;
      out_q.wdata <= stg[NSTG-2].high ? stg[NSTG-2].prod[2*XLEN-1:XLEN]
                                      : stg[NSTG-2].prod[XLEN-1:0];
    end
  end

  assign out_valid = out_valid_q;
  assign result    = out_q;

endmodule

//--- verilog/alu_branch_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_branch_unit (
  input  exec_pkg::issue_t        op,
  output exec_pkg::arith_result_t result
);

  localparam int XLEN    = `EXEC_XLEN;
  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  logic [XLEN-1:0]    a;
  logic [XLEN-1:0]    b;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_out;
  logic               lt_s;
  logic               lt_u;
  logic               eq;
  logic [XLEN-1:0]    pc4;
  logic [XLEN-1:0]    br_target;
  logic [XLEN-1:0]    jalr_sum;
  logic [XLEN-1:0]    jump_target;
  logic               is_branch;
  logic               is_jump;
  logic               is_jalr;
  logic               taken;
  logic               mispredict;

  assign a     = op.port_a;
  assign b     = op.port_b;
  assign shamt = b[SHAMT_W-1:0];

  // shared comparator for slt and the branches
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;
  assign eq   = (a == b);

  always_comb begin
    case (exec_pkg::alu_op_e'(op.opcode))
      exec_pkg::ALU_ADD:    alu_out = a + b;
      exec_pkg::ALU_SUB:    alu_out = a - b;
      exec_pkg::ALU_AND:    alu_out = a & b;
      exec_pkg::ALU_OR:     alu_out = a | b;
      exec_pkg::ALU_XOR:    alu_out = a ^ b;
      exec_pkg::ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lt_s};
      exec_pkg::ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, lt_u};
      exec_pkg::ALU_SLL:    alu_out = a << shamt;
      exec_pkg::ALU_SRL:    alu_out = a >> shamt;
      exec_pkg::ALU_SRA:    alu_out = $unsigned($signed(a) >>> shamt);
      exec_pkg::ALU_PASS_B: alu_out = b;
      default:              alu_out = '0;
    endcase
  end

  assign is_branch = (op.unit == exec_pkg::UNIT_BRANCH);
  assign is_jump   = (op.unit == exec_pkg::UNIT_JUMP);
  assign is_jalr   = is_jump && (op.opcode == exec_pkg::OP_JALR);

  // branch outcome
  always_comb begin
    case (exec_pkg::br_op_e'(op.opcode[2:0]))
      exec_pkg::BR_EQ:  taken = eq;
      exec_pkg::BR_NE:  taken = !eq;
      exec_pkg::BR_LT:  taken = lt_s;
      exec_pkg::BR_GE:  taken = !lt_s;
      exec_pkg::BR_LTU: taken = lt_u;
      exec_pkg::BR_GEU: taken = !lt_u;
      default:          taken = 1'b0;
    endcase
  end

  assign pc4       = op.pc + XLEN'(4);
  assign br_target = op.pc + op.imm;
  assign jalr_sum  = a + op.imm;

  // jal is pc relative, jalr drops bit 0 of rs1+imm
  assign jump_target = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : br_target;

  assign mispredict = is_branch && (taken != op.prediction);

  always_comb begin
    result.tag      = op.tag;
    result.rd       = op.rd;
    result.wen      = is_jump || (op.unit == exec_pkg::UNIT_ARITH);
    // link register value for jumps
    result.wdata    = is_jump ? pc4 : alu_out;
    result.redirect = is_jump || mispredict;
    if (is_jump) begin
      result.redirect_addr = jump_target;
    end else if (taken) begin
      result.redirect_addr = br_target;
    end else begin
      result.redirect_addr = pc4;
    end
  end

endmodule

//--- verilog/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

  // functional unit selected by decode
  typedef enum logic [1:0] {
    UNIT_ARITH  = 2'd0,
    UNIT_BRANCH = 2'd1,
    UNIT_JUMP   = 2'd2,
    UNIT_MUL    = 2'd3
  } exec_unit_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // branch compare kinds, low 3 bits of the op code
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_op_e;

  // multiply kinds, low 2 bits of the op code
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // jump unit op code for jalr, any other code resolves as jal
  localparam logic [3:0] OP_JALR = 4'd1;

  typedef struct packed {
    exec_unit_e             unit;
    logic [3:0]             opcode;
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic [`EXEC_XLEN-1:0]  port_a;
    logic [`EXEC_XLEN-1:0]  port_b;
    logic [`EXEC_XLEN-1:0]  pc;
    logic [`EXEC_XLEN-1:0]  imm;
    logic                   prediction;
  } issue_t;

  typedef struct packed {
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   wen;
    logic [`EXEC_XLEN-1:0]  wdata;
    logic                   redirect;
    logic [`EXEC_XLEN-1:0]  redirect_addr;
  } arith_result_t;

  typedef struct packed {
    logic [`EXEC_TAG_W-1:0] tag;
    logic [`EXEC_REG_W-1:0] rd;
    logic [`EXEC_XLEN-1:0]  wdata;
  } mul_result_t;

endpackage

//--- verilog/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width of the integer unit
`define EXEC_XLEN 32

// reorder-buffer tag width
`define EXEC_TAG_W 4

// architectural destination register index
`define EXEC_REG_W 5

// registered stages inside the multiplier
// result slot toward commit adds one more edge
`define EXEC_MUL_STAGES 2

`endif
